/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Word address width as seen by the fill engine and the host.
`define MEM_ADDR_WIDTH 32

// Width of one memory word.
`define MEM_DATA_WIDTH 32

// Bank geometry. Two banks of 32 words give 64 words in total.
// The bank tag is the address bit just above the in-bank address.
`define BANK_ADDR_WIDTH 5
`define BANK_DEPTH 32

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

	// Full word address. Only the low six bits reach the RAM.
	typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

	// One memory word.
	typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

	// Bank select, taken from address bit 5.
	typedef logic tag_t;

	// Word address inside one bank.
	typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;

endpackage

`default_nettype wire

/* fill_pkg.sv */
`default_nettype none

`include "mem_defines.svh"

package fill_pkg;

	// Fill length and progress counter. Spans the full address range.
	typedef logic [`MEM_ADDR_WIDTH-1:0] count_t;

	// Engine FSM states.
	typedef enum logic [1:0] {
		idle  = 2'd0,
		setup = 2'd1,
		write = 2'd2,
		done  = 2'd3
	} fill_state_t;

endpackage

`default_nettype wire

/* mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if
	import mem_pkg::*;
();

	addr_t address;
	logic write_enable;
	data_t wdata;
	data_t rdata; // Registered bank output, valid one cycle after the request.

	// Request side, the fill engine.
	modport initiator (
		output address,
		output write_enable,
		output wdata,
		input rdata
	);

	// Memory side, the controller.
	modport target (
		input address,
		input write_enable,
		input wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* single_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module single_port_ram
	import mem_pkg::*;
(
	input logic clk,
	input bank_addr_t address,
	input logic write_enable,
	input data_t wdata,
	output data_t rdata
);

	data_t words [`BANK_DEPTH];

	// One access per cycle. A write leaves the output register alone,
	// so the last read value stays visible.
	always_ff @(posedge clk)
	begin
		if (write_enable)
		begin
			words[address] <= wdata;
		end
		else
		begin
			rdata <= words[address];
		end
	end

endmodule

`default_nettype wire

/* memory_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module memory_controller
	import mem_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic busy,
	input addr_t rd_address,
	mem_bus_if.target bus,
	output data_t rd_data
);

	addr_t sel_address;
	logic sel_write;
	tag_t sel_tag;
	tag_t tag_q;
	bank_addr_t bank_address;
	logic bank0_we;
	logic bank1_we;
	data_t bank0_rdata;
	data_t bank1_rdata;

	// The engine owns the memory for the whole fill. The host address is
	// only looked at while the engine is idle.
	assign sel_address = busy ? bus.address : rd_address;
	assign sel_write = busy & bus.write_enable; // Host port is read only.

	// Addresses wrap modulo 64. Bit 5 picks the bank.
	assign sel_tag = sel_address[`BANK_ADDR_WIDTH];
	assign bank_address = sel_address[`BANK_ADDR_WIDTH-1:0];

	always_comb
	begin
		bank0_we = 1'b0;
		bank1_we = 1'b0;
		case (sel_tag)
			1'b0:
			begin
				bank0_we = sel_write;
			end
			1'b1:
			begin
				bank1_we = sel_write;
			end
			default:
			begin
				bank0_we = 1'b0;
				bank1_we = 1'b0;
			end
		endcase
	end

	single_port_ram bank0 (
		.clk(clk),
		.address(bank_address),
		.write_enable(bank0_we),
		.wdata(bus.wdata),
		.rdata(bank0_rdata)
	);

	single_port_ram bank1 (
		.clk(clk),
		.address(bank_address),
		.write_enable(bank1_we),
		.wdata(bus.wdata),
		.rdata(bank1_rdata)
	);

	// The bank outputs are registered, so the tag that selects between them
	// has to be delayed by the same cycle. It holds on write cycles because
	// neither bank updates its output then.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tag_q <= 1'b0;
		end
		else if (!sel_write)
		begin
			tag_q <= sel_tag;
		end
	end

	always_comb
	begin
		case (tag_q)
			1'b0: rd_data = bank0_rdata;
			1'b1: rd_data = bank1_rdata;
			default: rd_data = bank0_rdata;
		endcase
	end

	assign bus.rdata = rd_data; // Same data path for engine and host.

	// Every engine write must land in exactly one bank, which only happens
	// while busy hands the memory to the engine.
	a_one_bank_write: assert property (
		@(posedge clk) disable iff (reset)
		bus.write_enable |-> (bank0_we != bank1_we)
	);

endmodule

`default_nettype wire

/* memset_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module memset_engine
	import mem_pkg::*;
	import fill_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input addr_t m,
	input data_t c,
	input count_t n,
	output logic finish,
	output logic busy,
	output addr_t return_val,
	mem_bus_if.initiator bus
);

	fill_state_t state;
	fill_state_t state_next;

	addr_t base_q;
	data_t value_q;
	count_t total_q;
	count_t count_q;
	count_t count_inc;
	logic last_write;
	logic accept;

	// A request is only taken in idle. Pulses during a fill are dropped.
	assign accept = (state == idle) && start;

	assign count_inc = count_q + count_t'(1);
	assign last_write = (count_inc == total_q); // This cycle writes word n-1.

	always_comb
	begin
		state_next = state;
		case (state)
			idle:
			begin
				if (start)
				begin
					state_next = setup;
				end
			end
			setup:
			begin
				if (total_q == '0)
				begin
					state_next = done; // Nothing to write.
				end
				else
				begin
					state_next = write;
				end
			end
			write:
			begin
				if (last_write)
				begin
					state_next = done;
				end
			end
			done:
			begin
				state_next = idle;
			end
			default:
			begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	// m, c and n are only valid alongside start, so they are captured on
	// that edge and held for the whole fill.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			base_q <= m;
			value_q <= c;
			total_q <= n;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count_q <= '0;
		end
		else if (state == setup)
		begin
			count_q <= '0;
		end
		else if (state == write)
		begin
			count_q <= count_inc;
		end
	end

	// Outputs are registered from the next state. busy covers setup and
	// write and drops as the finish cycle starts.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			finish <= 1'b0;
			return_val <= '0;
		end
		else
		begin
			busy <= (state_next == setup) || (state_next == write);
			finish <= (state_next == done);
			if (state_next == done)
			begin
				return_val <= base_q;
			end
		end
	end

	// One word per cycle while in write.
	assign bus.write_enable = (state == write);
	assign bus.address = (state == write) ? base_q + count_q : '0;
	assign bus.wdata = value_q;

	// Writes happen only during the fill and never past the n requested words.
	a_write_only_in_write: assert property (
		@(posedge clk) disable iff (reset)
		bus.write_enable |-> busy && (count_q < total_q)
	);

	a_finish_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		finish |=> !finish
	);

endmodule

`default_nettype wire

/* memset_top.sv */
`timescale 1ns/10ps
`default_nettype none

module memset_top
	import mem_pkg::*;
	import fill_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input addr_t m,
	input data_t c,
	input count_t n,
	input addr_t rd_address,
	output logic finish,
	output logic busy,
	output addr_t return_val,
	output data_t rd_data
);

	// Request path from the engine to the controller.
	mem_bus_if bus ();

	memset_engine engine (
		.clk(clk),
		.reset(reset),
		.start(start),
		.m(m),
		.c(c),
		.n(n),
		.finish(finish),
		.busy(busy),
		.return_val(return_val),
		.bus(bus.initiator)
	);

	// busy also hands the memory back to the host port.
	memory_controller controller (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.rd_address(rd_address),
		.bus(bus.target),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* tb_memset.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module tb_memset
	import mem_pkg::*;
	import fill_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int MEM_WORDS = 2 * `BANK_DEPTH;
	localparam int NUM_DIRECTED = 6;
	localparam int NUM_RANDOM = 8;
	localparam int NUM_FILLS = NUM_DIRECTED + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_FILLS * 300 + 20;
	localparam logic [31:0] SEED = 32'h9b8b7c36;

	logic clk;
	logic reset;
	logic start;
	addr_t m;
	data_t c;
	count_t n;
	addr_t rd_address;
	logic finish;
	logic busy;
	addr_t return_val;
	data_t rd_data;

	data_t model [MEM_WORDS]; // Expected memory contents.
	logic reading;
	int due;
	addr_t fill_base;
	addr_t ret_hold;
	logic finish_expect;
	logic busy_expect;
	addr_t ret_expect;
	logic chk_q;
	data_t exp_q;
	addr_t addr_q;

	int data_errors;
	int timing_errors;
	int timeout_errors;

	memset_top dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.m(m),
		.c(c),
		.n(n),
		.rd_address(rd_address),
		.finish(finish),
		.busy(busy),
		.return_val(return_val),
		.rd_data(rd_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// A start taken in idle puts finish n+2 edges later. due counts down to it,
	// so it reads 1 on the edge that sees finish.
	always @(posedge clk)
	begin
		if (reset)
		begin
			due <= 0;
			fill_base <= '0;
			ret_hold <= '0;
		end
		else
		begin
			if (start && due == 0)
			begin
				due <= int'(n) + 2;
				fill_base <= m;
			end
			else if (due != 0)
			begin
				due <= due - 1;
			end
			if (due == 1)
			begin
				ret_hold <= fill_base;
			end
		end
	end

	assign finish_expect = (due == 1);
	assign busy_expect = (due > 1); // Busy from setup through the last write.
	assign ret_expect = (due == 1) ? fill_base : ret_hold;

	// Host reads answer one cycle later.
	always @(posedge clk)
	begin
		if (reset)
		begin
			chk_q <= 1'b0;
			exp_q <= '0;
			addr_q <= '0;
		end
		else
		begin
			chk_q <= reading;
			exp_q <= model[rd_address[5:0]];
			addr_q <= rd_address;
		end
	end

	a_finish_timing: assert property (
		@(posedge clk) disable iff (reset)
		finish == finish_expect
	)
	else
	begin
		timing_errors++;
		$display("[ERROR] finish: got %h, expected %h at %0t",
			$sampled(finish), $sampled(finish_expect), $time);
	end

	a_busy_timing: assert property (
		@(posedge clk) disable iff (reset)
		busy == busy_expect
	)
	else
	begin
		timing_errors++;
		$display("[ERROR] busy: got %h, expected %h at %0t",
			$sampled(busy), $sampled(busy_expect), $time);
	end

	a_return_val: assert property (
		@(posedge clk) disable iff (reset)
		return_val == ret_expect
	)
	else
	begin
		data_errors++;
		$display("[ERROR] return_val: got %h, expected %h at %0t",
			$sampled(return_val), $sampled(ret_expect), $time);
	end

	a_read_data: assert property (
		@(posedge clk) disable iff (reset)
		chk_q |-> rd_data == exp_q
	)
	else
	begin
		data_errors++;
		$display("[ERROR] rd_data at rd_address %h: got %h, expected %h",
			$sampled(addr_q), $sampled(rd_data), $sampled(exp_q));
	end

	// Starts one fill. A second start pulse can be given poke cycles after
	// the first; it falls inside the fill and must be dropped.
	task automatic run_fill(input addr_t fm, input data_t fc, input count_t fn,
		input int poke);
		int waited;
		int i;
		logic [5:0] idx;
		m = fm;
		c = fc;
		n = fn;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		m = $urandom;
		c = $urandom;
		n = $urandom;
		rd_address = $urandom; // Host address is ignored while busy.
		if (poke > 0)
		begin
			repeat (poke - 1) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		waited = 0;
		while (!finish && waited < int'(fn) + 10)
		begin
			@(negedge clk);
			waited++;
		end
		if (!finish)
		begin
			timeout_errors++;
			$display("Timeout: finish did not arrive within %0d cycles of start.", waited);
		end
		for (i = 0; i < int'(fn); i++)
		begin
			idx = fm[5:0] + 6'(i); // Wraps past word 63.
			model[idx] = fc;
		end
		@(negedge clk);
	endtask

	task automatic read_back();
		int a;
		for (a = 0; a < MEM_WORDS; a++)
		begin
			// Upper bits are random, only bits 5:0 pick the word.
			rd_address = ($urandom & 32'hffff_ffc0) | addr_t'(a);
			reading = 1'b1;
			@(negedge clk);
		end
		reading = 1'b0;
	endtask

	initial
	begin
		int f;
		addr_t fm;
		count_t fn;
		int poke;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		m = '0;
		c = '0;
		n = '0;
		rd_address = '0;
		reading = 1'b0;
		data_errors = 0;
		timing_errors = 0;
		timeout_errors = 0;
		void'($urandom(SEED));
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (3) @(negedge clk);

		run_fill($urandom, $urandom, 64, 0); // Whole memory, so every word is known.
		read_back();
		run_fill(28, $urandom, 10, 0); // Crosses from bank 0 into bank 1.
		read_back();
		run_fill(32'hffff_fffc, $urandom, 10, 0);
		read_back();
		run_fill($urandom, $urandom, 0, 1);
		read_back();
		run_fill(5, $urandom, 40, 17);
		read_back();
		run_fill(32'h0000_0120, $urandom, 1, 0);
		read_back();

		for (f = 0; f < NUM_RANDOM; f++)
		begin
			fm = $urandom;
			fn = $urandom_range(64, 0);
			poke = 0;
			if (fn != 0 && $urandom_range(1, 0) == 1)
			begin
				poke = $urandom_range(int'(fn) + 1, 1);
			end
			run_fill(fm, $urandom, fn, poke);
			read_back();
		end

		repeat (2) @(negedge clk);
		$display("Errors: data %0d, timing %0d, timeout %0d",
			data_errors, timing_errors, timeout_errors);
		if (data_errors + timing_errors + timeout_errors == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Each fill with its read back takes well under 300 cycles.
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the test did not complete.",
			WATCHDOG_CYCLES);
		$display("Errors: data %0d, timing %0d, timeout %0d",
			data_errors, timing_errors, timeout_errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mem_pkg.sv
fill_pkg.sv
mem_bus_if.sv
single_port_ram.sv
memory_controller.sv
memset_engine.sv
memset_top.sv
tb_memset.sv

/* Makefile */
SOURCES := $(filter-out +incdir+%,$(shell cat list.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_memset: list.f mem_defines.svh $(SOURCES)
	verilator --binary --timing --assert --top-module tb_memset -f list.f

run: obj_dir/Vtb_memset
	@out="$$(./obj_dir/Vtb_memset)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
